/* rvPkg.sv */
package rvPkg;

    localparam int XLEN = 64;
    localparam int ILEN = 32;  // instruction word
    localparam int WLEN = 32;  // word ops, the *W forms
    localparam int REGW = 5;   // register index

    typedef enum logic [6:0] {
        OP        = 7'b0110011,
        OP_IMM    = 7'b0010011,
        OP_32     = 7'b0111011,
        OP_IMM_32 = 7'b0011011,
        LUI       = 7'b0110111,
        AUIPC     = 7'b0010111,
        LOAD      = 7'b0000011,
        STORE     = 7'b0100011,
        BRANCH    = 7'b1100011,
        JAL       = 7'b1101111,
        JALR      = 7'b1100111,
        SYSTEM    = 7'b1110011
    } opcodeE;

    typedef enum logic [2:0] {
        IMM_NONE, IMM_I, IMM_S, IMM_B, IMM_U, IMM_J
    } immFmtE;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASSB
    } aluOpE;

    // nine kinds, so one bit wider than the funct3 it comes from
    typedef enum logic [3:0] {
        BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU, BR_JAL, BR_JALR
    } branchE;

    typedef enum logic [2:0] {
        MEM_NONE, MEM_B, MEM_BU, MEM_H, MEM_HU, MEM_W, MEM_WU, MEM_D
    } memOpE;

    typedef struct packed {
        aluOpE  aluOp;
        branchE branch;
        memOpE  memOp;
        logic   memWr;
        logic   regWr;
        logic   isWord;     // truncate to 32 bits, then sign extend
        logic   regSrcMem;  // load, rd would take the memory return
        logic   trapReq;
        logic   illegal;
    } ctrlT;

    typedef struct packed {
        logic            valid;
        ctrlT            ctrl;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] opA;
        logic [XLEN-1:0] opB;
        logic [XLEN-1:0] rs1Val;  // branch compare and jalr base
        logic [XLEN-1:0] rs2Val;
        logic [XLEN-1:0] imm;
        logic [REGW-1:0] rd;
    } decodedT;

    typedef struct packed {
        logic            valid;
        ctrlT            ctrl;
        logic [XLEN-1:0] aluResult;
        logic            branchTaken;
        logic [XLEN-1:0] branchTarget;
        logic [XLEN-1:0] storeData;
        logic [REGW-1:0] rd;
    } executedT;

endpackage

/* immGen.sv */
`timescale 1ns/1ps

module immGen (
    input  logic [rvPkg::ILEN-1:0] inst,
    input  rvPkg::immFmtE          fmt,
    output logic [rvPkg::XLEN-1:0] imm
);

    always_comb begin
        case (fmt)
            rvPkg::IMM_I: imm = {{(rvPkg::XLEN-12){inst[31]}}, inst[31:20]};
            rvPkg::IMM_S: imm = {{(rvPkg::XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};
            rvPkg::IMM_B: begin
                imm = {{(rvPkg::XLEN-13){inst[31]}}, inst[31], inst[7],
                       inst[30:25], inst[11:8], 1'b0};  // branch offset, halfwords
            end
            rvPkg::IMM_U: imm = {{(rvPkg::XLEN-32){inst[31]}}, inst[31:12], 12'b0};
            rvPkg::IMM_J: begin
                imm = {{(rvPkg::XLEN-21){inst[31]}}, inst[31], inst[19:12],
                       inst[20], inst[30:21], 1'b0};  // jal offset
            end
            default: imm = '0;
        endcase
    end

endmodule

/* decodeStage.sv */
`timescale 1ns/1ps

module decodeStage (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   instValid,
    input  logic [rvPkg::ILEN-1:0] inst,
    input  logic [rvPkg::XLEN-1:0] pc,
    input  logic [rvPkg::XLEN-1:0] rs1Val,
    input  logic [rvPkg::XLEN-1:0] rs2Val,
    output rvPkg::decodedT         decoded
);

    rvPkg::opcodeE          opcode;
    logic [2:0]             funct3;
    logic [6:0]             funct7;
    rvPkg::immFmtE          fmt;
    rvPkg::ctrlT            ctrl;
    logic [rvPkg::XLEN-1:0] imm;
    logic                   aIsPc;    // auipc, jal, jalr
    logic                   bIsImm;
    logic                   bIsFour;  // link address

    assign opcode = rvPkg::opcodeE'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    function automatic rvPkg::aluOpE aluFromFunct(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? rvPkg::ALU_SUB : rvPkg::ALU_ADD;
            3'b001:  return rvPkg::ALU_SLL;
            3'b010:  return rvPkg::ALU_SLT;
            3'b011:  return rvPkg::ALU_SLTU;
            3'b100:  return rvPkg::ALU_XOR;
            3'b101:  return alt ? rvPkg::ALU_SRA : rvPkg::ALU_SRL;
            3'b110:  return rvPkg::ALU_OR;
            default: return rvPkg::ALU_AND;
        endcase
    endfunction

    // same funct3 coding for loads and stores
    function automatic rvPkg::memOpE memFromFunct(input logic [2:0] f3);
        case (f3)
            3'b000:  return rvPkg::MEM_B;
            3'b001:  return rvPkg::MEM_H;
            3'b010:  return rvPkg::MEM_W;
            3'b011:  return rvPkg::MEM_D;
            3'b100:  return rvPkg::MEM_BU;
            3'b101:  return rvPkg::MEM_HU;
            3'b110:  return rvPkg::MEM_WU;
            default: return rvPkg::MEM_NONE;
        endcase
    endfunction

    function automatic rvPkg::branchE branchFromFunct(input logic [2:0] f3);
        case (f3)
            3'b000:  return rvPkg::BR_EQ;
            3'b001:  return rvPkg::BR_NE;
            3'b100:  return rvPkg::BR_LT;
            3'b101:  return rvPkg::BR_GE;
            3'b110:  return rvPkg::BR_LTU;
            3'b111:  return rvPkg::BR_GEU;
            default: return rvPkg::BR_NONE;
        endcase
    endfunction

    immGen immGen_inst (
        .inst (inst),
        .fmt  (fmt),
        .imm  (imm)
    );

    always_comb begin
        ctrl    = '0;
        fmt     = rvPkg::IMM_NONE;
        aIsPc   = 1'b0;
        bIsImm  = 1'b0;
        bIsFour = 1'b0;
        casez ({funct7, funct3, opcode})
            {7'b0000000, 3'b???, rvPkg::OP},
            {7'b0100000, 3'b000, rvPkg::OP},
            {7'b0100000, 3'b101, rvPkg::OP},
            {7'b0000000, 3'b00?, rvPkg::OP_32},
            {7'b0?00000, 3'b101, rvPkg::OP_32},
            {7'b0100000, 3'b000, rvPkg::OP_32}: begin  // add sub sll ... and, addw ... sraw
                ctrl.regWr  = 1'b1;
                ctrl.isWord = opcode[3];
                ctrl.aluOp  = aluFromFunct(funct3, funct7[5]);
            end
            {7'b???????, 3'b000, rvPkg::OP_IMM},
            {7'b???????, 3'b01?, rvPkg::OP_IMM},
            {7'b???????, 3'b1?0, rvPkg::OP_IMM},
            {7'b???????, 3'b111, rvPkg::OP_IMM},
            {7'b000000?, 3'b001, rvPkg::OP_IMM},   // slli, 6 bit shamt
            {7'b0?0000?, 3'b101, rvPkg::OP_IMM},
            {7'b???????, 3'b000, rvPkg::OP_IMM_32},
            {7'b0000000, 3'b001, rvPkg::OP_IMM_32},
            {7'b0?00000, 3'b101, rvPkg::OP_IMM_32}: begin
                ctrl.regWr  = 1'b1;
                ctrl.isWord = opcode[3];
                ctrl.aluOp  = aluFromFunct(funct3, funct3 == 3'b101 && funct7[5]);
                fmt         = rvPkg::IMM_I;
                bIsImm      = 1'b1;
            end
            {7'b???????, 3'b0??, rvPkg::LOAD},
            {7'b???????, 3'b10?, rvPkg::LOAD},
            {7'b???????, 3'b110, rvPkg::LOAD}: begin
                ctrl.regWr     = 1'b1;
                ctrl.regSrcMem = 1'b1;
                ctrl.memOp     = memFromFunct(funct3);
                fmt            = rvPkg::IMM_I;
                bIsImm         = 1'b1;
            end
            {7'b???????, 3'b0??, rvPkg::STORE}: begin  // sb sh sw sd
                ctrl.memWr = 1'b1;
                ctrl.memOp = memFromFunct(funct3);
                fmt        = rvPkg::IMM_S;
                bIsImm     = 1'b1;
            end
            {7'b???????, 3'b00?, rvPkg::BRANCH},
            {7'b???????, 3'b1??, rvPkg::BRANCH}: begin
                ctrl.branch = branchFromFunct(funct3);
                fmt         = rvPkg::IMM_B;
            end
            {7'b???????, 3'b???, rvPkg::JAL}: begin
                ctrl.regWr  = 1'b1;
                ctrl.branch = rvPkg::BR_JAL;
                fmt         = rvPkg::IMM_J;
                aIsPc       = 1'b1;
                bIsFour     = 1'b1;
            end
            {7'b???????, 3'b000, rvPkg::JALR}: begin
                ctrl.regWr  = 1'b1;
                ctrl.branch = rvPkg::BR_JALR;
                fmt         = rvPkg::IMM_I;
                aIsPc       = 1'b1;
                bIsFour     = 1'b1;
            end
            {7'b???????, 3'b???, rvPkg::LUI}: begin
                ctrl.regWr = 1'b1;
                ctrl.aluOp = rvPkg::ALU_PASSB;
                fmt        = rvPkg::IMM_U;
                bIsImm     = 1'b1;
            end
            {7'b???????, 3'b???, rvPkg::AUIPC}: begin
                ctrl.regWr = 1'b1;
                fmt        = rvPkg::IMM_U;
                aIsPc      = 1'b1;
                bIsImm     = 1'b1;
            end
            {7'b???????, 3'b???, rvPkg::SYSTEM}: begin  // ecall, ebreak, csr*
                ctrl.trapReq = 1'b1;
                fmt          = rvPkg::IMM_I;
            end
            default: ctrl.illegal = 1'b1;  // no writes of any kind
        endcase
    end

    always_ff @(posedge clk) begin
        decoded.pc     <= pc;
        decoded.opA    <= aIsPc ? pc : rs1Val;
        decoded.opB    <= bIsFour ? rvPkg::XLEN'(4) : (bIsImm ? imm : rs2Val);
        decoded.rs1Val <= rs1Val;
        decoded.rs2Val <= rs2Val;
        decoded.imm    <= imm;
        decoded.rd     <= inst[11:7];
        if (rst) begin
            decoded.valid <= 1'b0;
            decoded.ctrl  <= '0;
        end else begin
            decoded.valid <= instValid;
            decoded.ctrl  <= instValid ? ctrl : '0;  // flags only live with valid
        end
    end

    // a slot either writes memory or the register file, never both
    assert property (@(posedge clk) disable iff (rst)
        decoded.valid |-> !(decoded.ctrl.memWr && decoded.ctrl.regWr));

endmodule

/* executeStage.sv */
`timescale 1ns/1ps

module executeStage (
    input  logic             clk,
    input  logic             rst,
    input  rvPkg::decodedT   decoded,
    output rvPkg::executedT  executed
);

    logic [rvPkg::XLEN-1:0] shIn;
    logic [5:0]             shAmt;
    logic [rvPkg::XLEN-1:0] aluResult;
    logic [rvPkg::XLEN-1:0] jalrSum;
    logic [rvPkg::XLEN-1:0] target;
    logic                   taken;

    always_comb begin
        if (decoded.ctrl.isWord) begin
            shAmt = {1'b0, decoded.opB[4:0]};
            // low word only, extended so right shifts pull in the proper bits
            if (decoded.ctrl.aluOp == rvPkg::ALU_SRA) begin
                shIn = {{(rvPkg::XLEN-rvPkg::WLEN){decoded.opA[rvPkg::WLEN-1]}},
                        decoded.opA[rvPkg::WLEN-1:0]};
            end else begin
                shIn = {{(rvPkg::XLEN-rvPkg::WLEN){1'b0}}, decoded.opA[rvPkg::WLEN-1:0]};
            end
        end else begin
            shAmt = decoded.opB[5:0];
            shIn  = decoded.opA;
        end
    end

    always_comb begin
        case (decoded.ctrl.aluOp)
            rvPkg::ALU_ADD:   aluResult = decoded.opA + decoded.opB;
            rvPkg::ALU_SUB:   aluResult = decoded.opA - decoded.opB;
            rvPkg::ALU_SLL:   aluResult = shIn << shAmt;
            rvPkg::ALU_SLT: begin
                aluResult = {{(rvPkg::XLEN-1){1'b0}},
                             $signed(decoded.opA) < $signed(decoded.opB)};
            end
            rvPkg::ALU_SLTU:  aluResult = {{(rvPkg::XLEN-1){1'b0}}, decoded.opA < decoded.opB};
            rvPkg::ALU_XOR:   aluResult = decoded.opA ^ decoded.opB;
            rvPkg::ALU_SRL:   aluResult = shIn >> shAmt;
            rvPkg::ALU_SRA:   aluResult = $signed(shIn) >>> shAmt;
            rvPkg::ALU_OR:    aluResult = decoded.opA | decoded.opB;
            rvPkg::ALU_AND:   aluResult = decoded.opA & decoded.opB;
            rvPkg::ALU_PASSB: aluResult = decoded.opB;  // lui
            default:          aluResult = '0;
        endcase
    end

    always_comb begin
        case (decoded.ctrl.branch)
            rvPkg::BR_EQ:  taken = decoded.rs1Val == decoded.rs2Val;
            rvPkg::BR_NE:  taken = decoded.rs1Val != decoded.rs2Val;
            rvPkg::BR_LT:  taken = $signed(decoded.rs1Val) < $signed(decoded.rs2Val);
            rvPkg::BR_GE:  taken = $signed(decoded.rs1Val) >= $signed(decoded.rs2Val);
            rvPkg::BR_LTU: taken = decoded.rs1Val < decoded.rs2Val;
            rvPkg::BR_GEU: taken = decoded.rs1Val >= decoded.rs2Val;
            rvPkg::BR_JAL,
            rvPkg::BR_JALR: taken = 1'b1;
            default:       taken = 1'b0;  // also every invalid slot
        endcase
        jalrSum = decoded.rs1Val + decoded.imm;
        target  = (decoded.ctrl.branch == rvPkg::BR_JALR) ?
                  {jalrSum[rvPkg::XLEN-1:1], 1'b0} : decoded.pc + decoded.imm;
    end

    always_ff @(posedge clk) begin
        executed.aluResult    <= aluResult;  // memory address for loads and stores
        executed.branchTarget <= target;
        executed.storeData    <= decoded.rs2Val;
        executed.rd           <= decoded.rd;
        if (rst) begin
            executed.valid       <= 1'b0;
            executed.ctrl        <= '0;
            executed.branchTaken <= 1'b0;
        end else begin
            executed.valid       <= decoded.valid;
            executed.ctrl        <= decoded.ctrl;
            executed.branchTaken <= taken;
        end
    end

    // taken only for a live slot that decode marked as branch or jump
    assert property (@(posedge clk) disable iff (rst)
        executed.branchTaken |-> executed.valid && executed.ctrl.branch != rvPkg::BR_NONE);

endmodule

/* writebackStage.sv */
`timescale 1ns/1ps

module writebackStage (
    input  logic                   clk,
    input  logic                   rst,
    input  rvPkg::executedT        executed,
    output logic                   outValid,
    output logic [rvPkg::REGW-1:0] rd,
    output logic [rvPkg::XLEN-1:0] wbData,
    output logic                   regWr,
    output logic                   branchTaken,
    output logic [rvPkg::XLEN-1:0] branchTarget,
    output logic [rvPkg::XLEN-1:0] memAddr,
    output logic [rvPkg::XLEN-1:0] storeData,
    output logic                   memWr,
    output rvPkg::memOpE           memOp,
    output logic                   trapReq,
    output logic                   illegal
);

    logic [rvPkg::XLEN-1:0] result;

    // word ops keep the low half, sign extended
    assign result = executed.ctrl.isWord ?
                    {{(rvPkg::XLEN-rvPkg::WLEN){executed.aluResult[rvPkg::WLEN-1]}},
                     executed.aluResult[rvPkg::WLEN-1:0]} : executed.aluResult;

    always_ff @(posedge clk) begin
        rd           <= executed.rd;
        wbData       <= result;  // address for loads until data returns
        branchTarget <= executed.branchTarget;
        memAddr      <= executed.aluResult;
        storeData    <= executed.storeData;
        if (rst) begin
            outValid    <= 1'b0;
            regWr       <= 1'b0;
            branchTaken <= 1'b0;
            memWr       <= 1'b0;
            memOp       <= rvPkg::MEM_NONE;
            trapReq     <= 1'b0;
            illegal     <= 1'b0;
        end else begin
            outValid    <= executed.valid;
            regWr       <= executed.ctrl.regWr;
            branchTaken <= executed.branchTaken;
            memWr       <= executed.ctrl.memWr;
            memOp       <= executed.ctrl.memOp;
            trapReq     <= executed.ctrl.trapReq;
            illegal     <= executed.ctrl.illegal;
        end
    end

    // load slots from decode must still write rd and carry a size
    assert property (@(posedge clk) disable iff (rst)
        executed.ctrl.regSrcMem |-> executed.ctrl.regWr && !executed.ctrl.memWr
                                    && executed.ctrl.memOp != rvPkg::MEM_NONE);

endmodule

/* rvExecPipe.sv */
`timescale 1ns/1ps

module rvExecPipe (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   instValid,
    input  logic [rvPkg::ILEN-1:0] inst,
    input  logic [rvPkg::XLEN-1:0] pc,
    input  logic [rvPkg::XLEN-1:0] rs1Val,
    input  logic [rvPkg::XLEN-1:0] rs2Val,
    output logic                   outValid,
    output logic [rvPkg::REGW-1:0] rd,
    output logic [rvPkg::XLEN-1:0] wbData,
    output logic                   regWr,
    output logic                   branchTaken,
    output logic [rvPkg::XLEN-1:0] branchTarget,
    output logic [rvPkg::XLEN-1:0] memAddr,
    output logic [rvPkg::XLEN-1:0] storeData,
    output logic                   memWr,
    output rvPkg::memOpE           memOp,
    output logic                   trapReq,
    output logic                   illegal
);

    rvPkg::decodedT  decoded;   // decode to execute
    rvPkg::executedT executed;  // execute to writeback

    decodeStage decodeStage_inst (
        .clk       (clk),
        .rst       (rst),
        .instValid (instValid),
        .inst      (inst),
        .pc        (pc),
        .rs1Val    (rs1Val),
        .rs2Val    (rs2Val),
        .decoded   (decoded)
    );

    executeStage executeStage_inst (
        .clk      (clk),
        .rst      (rst),
        .decoded  (decoded),
        .executed (executed)
    );

    writebackStage writebackStage_inst (
        .clk          (clk),
        .rst          (rst),
        .executed     (executed),
        .outValid     (outValid),
        .rd           (rd),
        .wbData       (wbData),
        .regWr        (regWr),
        .branchTaken  (branchTaken),
        .branchTarget (branchTarget),
        .memAddr      (memAddr),
        .storeData    (storeData),
        .memWr        (memWr),
        .memOp        (memOp),
        .trapReq      (trapReq),
        .illegal      (illegal)
    );

endmodule

/* tbRvExecPipe.sv */
`timescale 1ns/1ps

module tbRvExecPipe;

    typedef struct packed {
        logic                   valid;
        logic [rvPkg::REGW-1:0] rd;
        logic [rvPkg::XLEN-1:0] wbData;
        logic                   regWr;
        logic                   branchTaken;
        logic [rvPkg::XLEN-1:0] branchTarget;
        logic [rvPkg::XLEN-1:0] memAddr;
        logic [rvPkg::XLEN-1:0] storeData;
        logic                   memWr;
        rvPkg::memOpE           memOp;
        logic                   trapReq;
        logic                   illegal;
    } expT;

    logic                   clk;
    logic                   rst;
    logic                   instValid;
    logic [rvPkg::ILEN-1:0] inst;
    logic [rvPkg::XLEN-1:0] pc;
    logic [rvPkg::XLEN-1:0] rs1Val;
    logic [rvPkg::XLEN-1:0] rs2Val;
    logic                   outValid;
    logic [rvPkg::REGW-1:0] rd;
    logic [rvPkg::XLEN-1:0] wbData;
    logic                   regWr;
    logic                   branchTaken;
    logic [rvPkg::XLEN-1:0] branchTarget;
    logic [rvPkg::XLEN-1:0] memAddr;
    logic [rvPkg::XLEN-1:0] storeData;
    logic                   memWr;
    rvPkg::memOpE           memOp;
    logic                   trapReq;
    logic                   illegal;

    expT [2:0] pipe;      // expected results, one per pipeline stage
    expT       head;
    logic [8:0] flagsDut;
    logic [8:0] flagsExp;
    int        issued = 0;
    int        results = 0;
    int        errors = 0;
    bit        timedOut = 1'b0;

    rvExecPipe rvExecPipe_inst (
        .clk (clk), .rst (rst), .instValid (instValid), .inst (inst), .pc (pc),
        .rs1Val (rs1Val), .rs2Val (rs2Val), .outValid (outValid), .rd (rd),
        .wbData (wbData), .regWr (regWr), .branchTaken (branchTaken),
        .branchTarget (branchTarget), .memAddr (memAddr), .storeData (storeData),
        .memWr (memWr), .memOp (memOp), .trapReq (trapReq), .illegal (illegal)
    );

    // random word from the legal encodings, now and then an illegal one
    function automatic logic [31:0] randomInst();
        logic [31:0] w;
        logic [2:0]  f3;
        logic [2:0]  f3w;  // 0, 1 or 5 for the word forms
        logic [5:0]  top6;
        logic [6:0]  top7;
        logic        alt;
        int          pick;
        w    = $urandom;
        pick = $urandom % 13;
        f3   = w[14:12];
        alt  = w[30];
        f3w  = w[13] ? 3'b101 : {2'b00, w[12]};
        top6 = (f3 == 3'd1) ? 6'd0 : ((f3 == 3'd5) ? {1'b0, alt, 4'b0} : w[31:26]);
        top7 = (f3w == 3'd0) ? w[31:25] : {1'b0, alt && f3w == 3'd5, 5'b0};
        case (pick)
            0:  return {1'b0, alt && (f3 == 3'd0 || f3 == 3'd5), 5'b0, w[24:15], f3, w[11:7],
                        rvPkg::OP};
            1:  return {top6, w[25:15], f3, w[11:7], rvPkg::OP_IMM};
            2:  return {1'b0, alt && f3w != 3'd1, 5'b0, w[24:15], f3w, w[11:7], rvPkg::OP_32};
            3:  return {top7, w[24:15], f3w, w[11:7], rvPkg::OP_IMM_32};
            4:  return {w[31:7], rvPkg::LUI};
            5:  return {w[31:7], rvPkg::AUIPC};
            6:  return {w[31:7], rvPkg::JAL};
            7:  return {w[31:15], 3'b000, w[11:7], rvPkg::JALR};
            8:  return {w[31:15], (f3 == 3'd7) ? 3'd6 : f3, w[11:7], rvPkg::LOAD};
            9:  return {w[31:15], 1'b0, w[13:12], w[11:7], rvPkg::STORE};
            10: return {w[31:15], w[14], w[14] & w[13], w[12], w[11:7], rvPkg::BRANCH};
            11: return {w[31:7], rvPkg::SYSTEM};
            default: begin
                // unknown opcode, or an M extension word
                return w[0] ? {w[31:7], 7'h7f} : {7'b0000001, w[24:15], f3, w[11:7], rvPkg::OP};
            end
        endcase
    endfunction

    // expected outputs straight from the RV64I encoding rules
    function automatic expT expectFor(input logic [31:0] w, input logic [63:0] pcv,
                                      input logic [63:0] a, input logic [63:0] b);
        expT          e;
        logic [6:0]   opc;
        logic [6:0]   f7;
        logic [2:0]   f3;
        logic [63:0]  iI;
        logic [63:0]  iS;
        logic [63:0]  iB;
        logic [63:0]  iU;
        logic [63:0]  iJ;
        logic [63:0]  src2;
        logic [63:0]  r;
        logic [31:0]  lo;
        logic [5:0]   sh;
        logic         alt;
        logic         ok;
        rvPkg::memOpE sz;
        opc = w[6:0];
        f3  = w[14:12];
        f7  = w[31:25];
        iI  = {{52{w[31]}}, w[31:20]};
        iS  = {{52{w[31]}}, w[31:25], w[11:7]};
        iB  = {{51{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        iU  = {{32{w[31]}}, w[31:12], 12'b0};
        iJ  = {{43{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        case (f3)  // access size, loads and stores alike
            3'd0:    sz = rvPkg::MEM_B;
            3'd1:    sz = rvPkg::MEM_H;
            3'd2:    sz = rvPkg::MEM_W;
            3'd3:    sz = rvPkg::MEM_D;
            3'd4:    sz = rvPkg::MEM_BU;
            3'd5:    sz = rvPkg::MEM_HU;
            default: sz = rvPkg::MEM_WU;
        endcase
        e       = '0;
        e.valid = 1'b1;
        e.rd    = w[11:7];
        ok      = 1'b1;
        case (opc)
            rvPkg::OP, rvPkg::OP_IMM, rvPkg::OP_32, rvPkg::OP_IMM_32: begin
                if (opc == rvPkg::OP) begin
                    ok = f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
                end else if (opc == rvPkg::OP_32) begin
                    ok = (f3 == 3'd0 || f3 == 3'd1 || f3 == 3'd5)
                         && (f7 == 7'h00 || (f7 == 7'h20 && f3 != 3'd1));
                end else if (opc == rvPkg::OP_IMM) begin
                    ok = (f3 == 3'd1) ? f7[6:1] == 6'd0 : (f3 != 3'd5 || {f7[6], f7[4:1]} == 5'd0);
                end else begin
                    ok = f3 == 3'd0 || (f3 == 3'd1 && f7 == 7'h00)
                         || (f3 == 3'd5 && {f7[6], f7[4:0]} == 6'd0);
                end
                src2 = opc[5] ? b : iI;                    // opcode bit 5 marks rs2 forms
                alt  = f7[5] && (opc[5] || f3 == 3'd5);    // sub, sra
                sh   = opc[3] ? {1'b0, src2[4:0]} : src2[5:0];  // bit 3 marks word forms
                lo   = a[31:0];
                case (f3)
                    3'd0: r = alt ? a - src2 : a + src2;
                    3'd1: r = a << sh;
                    3'd2: r = {63'b0, $signed(a) < $signed(src2)};
                    3'd3: r = {63'b0, a < src2};
                    3'd4: r = a ^ src2;
                    3'd6: r = a | src2;
                    3'd7: r = a & src2;
                    default: begin
                        if (opc[3] && alt) r = {32'b0, $signed(lo) >>> sh};
                        else if (opc[3])   r = {32'b0, lo >> sh};
                        else if (alt)      r = $signed(a) >>> sh;
                        else               r = a >> sh;
                    end
                endcase
                if (opc[3]) r = {{32{r[31]}}, r[31:0]};
                e.regWr  = 1'b1;
                e.wbData = r;
            end
            rvPkg::LUI, rvPkg::AUIPC: begin
                e.regWr  = 1'b1;
                e.wbData = (opc == rvPkg::LUI) ? iU : pcv + iU;
            end
            rvPkg::JAL, rvPkg::JALR: begin
                ok                 = opc == rvPkg::JAL || f3 == 3'd0;
                e.regWr            = 1'b1;
                e.wbData           = pcv + 64'd4;  // link address
                e.branchTaken      = 1'b1;
                e.branchTarget     = (opc == rvPkg::JAL) ? pcv + iJ : (a + iI) & ~64'd1;
            end
            rvPkg::LOAD: begin
                ok        = f3 != 3'd7;
                e.regWr   = 1'b1;
                e.memAddr = a + iI;
                e.wbData  = a + iI;
                e.memOp   = sz;
            end
            rvPkg::STORE: begin
                ok          = !f3[2];
                e.memWr     = 1'b1;
                e.memAddr   = a + iS;
                e.storeData = b;
                e.memOp     = sz;
            end
            rvPkg::BRANCH: begin
                ok             = f3[2:1] != 2'b01;
                e.branchTarget = pcv + iB;
                case (f3)
                    3'd0:    e.branchTaken = a == b;
                    3'd1:    e.branchTaken = a != b;
                    3'd4:    e.branchTaken = $signed(a) < $signed(b);
                    3'd5:    e.branchTaken = $signed(a) >= $signed(b);
                    3'd6:    e.branchTaken = a < b;
                    default: e.branchTaken = a >= b;
                endcase
            end
            rvPkg::SYSTEM: e.trapReq = 1'b1;
            default:       ok = 1'b0;
        endcase
        if (!ok) begin
            e         = '0;
            e.valid   = 1'b1;
            e.illegal = 1'b1;
        end
        return e;
    endfunction

    task automatic reportMismatch(input string what, input logic [63:0] got,
                                  input logic [63:0] want);
        errors++;
        $display("** Error @ %0t ns: %s is %0h, expected %0h", $time, what, got, want);
    endtask

    // three registers, same depth as the pipeline
    always @(posedge clk) begin
        if (rst) begin
            pipe <= '0;
        end else if (instValid) begin
            pipe <= {pipe[1:0], expectFor(inst, pc, rs1Val, rs2Val)};
        end else begin
            pipe <= {pipe[1:0], expT'('0)};
        end
    end

    always @(posedge clk) begin
        if (!rst && instValid) issued++;
        if (!rst && outValid) results++;
    end

    assign head     = pipe[2];
    assign flagsDut = {outValid, regWr, memWr, branchTaken, trapReq, illegal, memOp};
    assign flagsExp = {head.valid, head.regWr, head.memWr, head.branchTaken, head.trapReq,
                       head.illegal, head.memOp};

    checkFlags: assert property (@(posedge clk) disable iff (rst) flagsDut == flagsExp)
        else reportMismatch("valid/flags/memOp", 64'($sampled(flagsDut)), 64'($sampled(flagsExp)));
    checkRd: assert property (@(posedge clk) disable iff (rst) head.regWr |-> rd == head.rd)
        else reportMismatch("rd", 64'($sampled(rd)), 64'($sampled(head.rd)));
    checkWb: assert property (@(posedge clk) disable iff (rst)
        head.regWr |-> wbData == head.wbData)
        else reportMismatch("wbData", $sampled(wbData), $sampled(head.wbData));
    checkTarget: assert property (@(posedge clk) disable iff (rst)
        head.branchTaken |-> branchTarget == head.branchTarget)
        else reportMismatch("branchTarget", $sampled(branchTarget), $sampled(head.branchTarget));
    checkAddr: assert property (@(posedge clk) disable iff (rst)
        head.memOp != rvPkg::MEM_NONE |-> memAddr == head.memAddr)
        else reportMismatch("memAddr", $sampled(memAddr), $sampled(head.memAddr));
    checkStore: assert property (@(posedge clk) disable iff (rst)
        head.memWr |-> storeData == head.storeData)
        else reportMismatch("storeData", $sampled(storeData), $sampled(head.storeData));

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        logic [63:0] a;
        logic [63:0] b;
        int          waitCycles;
        void'($urandom(2));
        rst       = 1'b1;
        instValid = 1'b0;
        inst      = '0;
        pc        = '0;
        rs1Val    = '0;
        rs2Val    = '0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        for (int n = 0; n < 3000; n++) begin
            @(posedge clk);
            a = {$urandom, $urandom};
            b = ($urandom % 4 == 0) ? a : {$urandom, $urandom};  // equal operands now and then
            instValid <= ($urandom % 8) != 0;
            inst      <= randomInst();
            pc        <= {$urandom, $urandom};
            rs1Val    <= a;
            rs2Val    <= b;
        end
        @(posedge clk);
        instValid <= 1'b0;
        waitCycles = 0;
        while (results < issued && waitCycles < 50) begin  // drain the pipeline
            @(negedge clk);
            waitCycles++;
        end
        if (results == 0) begin
            $display("timeout: the pipeline produced no results, outValid never went high");
            timedOut = 1'b1;
        end else if (results < issued) begin
            $display("timeout: only %0d of %0d results came out", results, issued);
            timedOut = 1'b1;
        end
        $display("issued %0d, results %0d, errors %0d", issued, results, errors);
        if (errors == 0 && !timedOut) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* build.f */
rvPkg.sv
immGen.sv
decodeStage.sv
executeStage.sv
writebackStage.sv
rvExecPipe.sv
tbRvExecPipe.sv

/* Makefile */
TOP       ?= tbRvExecPipe
FILELIST  ?= build.f
OBJDIR    ?= obj_dir
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert --timing -j 0
LOG       ?= sim.log

SIMBIN  := $(OBJDIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIMBIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(SIMBIN)
	./$(SIMBIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@! grep -q "TESTS FAILED" $(LOG) && grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
